// File: design/axi_wr_pkg.sv
package axi_wr_pkg;

    // ---------------------------------------------------------------------------
    // AXI4 write-side types
    // ---------------------------------------------------------------------------

    // INCR burst limit of AXI4
    localparam int MAX_BURST_BEATS = 256;

    // slave address as it goes on AWADDR
    typedef logic [31:0] axi_addr_t;

    // beats minus one, as on AWLEN
    typedef logic [7:0] axi_len_t;

    // write response code, bit 1 flags an error
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // AW payload, 40 bits
    typedef struct packed {
        axi_addr_t addr;
        axi_len_t  len;
    } aw_chan_t;

endpackage

// File: design/wr_ctrl_pkg.sv
package wr_ctrl_pkg;

    import axi_wr_pkg::*;

    // ---------------------------------------------------------------------------
    // controller-side types and byte offset helpers
    // ---------------------------------------------------------------------------

    // widest strobe the mask helpers cover (1024-bit bus)
    localparam int MAX_STRB_W = 128;

    typedef logic [MAX_STRB_W-1:0] strb_max_t;
    typedef logic [6:0]            byte_off_t;

    // one burst as handed from planner to data channel
    typedef struct packed {
        axi_len_t len;
        logic     is_first;
        logic     is_final;
    } burst_desc_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        ADDR,
        DATA_RESP
    } planner_state_e;

    // keeps bytes from off upward
    function automatic strb_max_t lead_mask(input byte_off_t off);
        return {MAX_STRB_W{1'b1}} << off;
    endfunction

    // keeps the low n bytes, 0 means the whole word
    function automatic strb_max_t tail_mask(input byte_off_t n);
        strb_max_t m;
        m = (n == '0) ? {MAX_STRB_W{1'b1}} : ((strb_max_t'(1) << n) - strb_max_t'(1));
        return m;
    endfunction

endpackage

// File: design/wr_burst_planner.sv
module wr_burst_planner
    import axi_wr_pkg::*;
    import wr_ctrl_pkg::*;
#(
    parameter int ADDR_W  = 32,
    parameter int DATA_W  = 32,
    parameter int BYTES_W = 16,
    localparam int STRB_W = DATA_W / 8,
    localparam int OFF_W  = $clog2(STRB_W)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [ADDR_W-1:0]  base_addr_i,
    input  logic [BYTES_W-1:0] byte_num_i,
    input  logic               start_i,
    input  logic               b_fire_i,
    input  logic               aw_ready_i,
    output aw_chan_t           aw_o,
    output logic               aw_valid_o,
    output logic               aw_fire_o,
    output burst_desc_t        desc_o,
    output logic [OFF_W-1:0]   start_off_o,
    output logic [OFF_W-1:0]   tail_bytes_o,
    output logic               busy_o
);

    // bytes moved by one full-length burst
    localparam int unsigned MAX_BYTES = MAX_BURST_BEATS * STRB_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BYTES_W:0]  rem_t;
    typedef logic [OFF_W-1:0]  off_t;

    planner_state_e     state_q;
    logic               first_pend_q;
    addr_t              addr_q;
    rem_t               rem_q;
    rem_t               req_bytes;
    off_t               base_off;
    off_t               start_off_q;
    off_t               tail_q;
    burst_desc_t        desc_q;
    logic [BYTES_W+1:0] words_up;
    axi_len_t           len_calc;
    logic               final_calc;

    // count from the aligned word, so the lead bytes are included
    assign base_off  = base_addr_i[OFF_W-1:0];
    assign req_bytes = rem_t'(byte_num_i) + rem_t'(base_off);

    // ---------------------------------------------------------------------------
    // burst sizing
    // ---------------------------------------------------------------------------

    always_comb begin
        words_up   = ({1'b0, rem_q} + (BYTES_W+2)'(STRB_W - 1)) >> OFF_W;
        final_calc = (rem_q <= MAX_BYTES);
        if (final_calc) begin
            len_calc = axi_len_t'(words_up - 1'b1);
        end else begin
            len_calc = axi_len_t'(MAX_BURST_BEATS - 1);
        end
    end

    // ---------------------------------------------------------------------------
    // FSM
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            first_pend_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q      <= ISSUE;
                        first_pend_q <= 1'b1;
                    end
                end
                ISSUE: begin
                    state_q <= ADDR;
                end
                ADDR: begin
                    if (aw_fire_o) begin
                        state_q      <= DATA_RESP;
                        first_pend_q <= 1'b0;
                    end
                end
                DATA_RESP: begin
                    // one burst in flight, wait for its response
                    if (b_fire_i) begin
                        state_q <= desc_q.is_final ? IDLE : ISSUE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request capture and byte accounting
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            addr_q      <= {base_addr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
            rem_q       <= req_bytes;
            start_off_q <= base_off;
            tail_q      <= req_bytes[OFF_W-1:0];
        end else if (aw_fire_o) begin
            addr_q <= addr_q + addr_t'(MAX_BYTES);
            if (rem_q > MAX_BYTES) begin
                rem_q <= rem_t'(rem_q - MAX_BYTES);
            end else begin
                rem_q <= '0;
            end
        end
        if (state_q == ISSUE) begin
            desc_q.len      <= len_calc;
            desc_q.is_first <= first_pend_q;
            desc_q.is_final <= final_calc;
        end
    end

    assign busy_o       = (state_q != IDLE);
    assign aw_valid_o   = (state_q == ADDR);
    assign aw_fire_o    = aw_valid_o & aw_ready_i;
    assign aw_o.addr    = axi_addr_t'(addr_q);
    assign aw_o.len     = desc_q.len;
    assign desc_o       = desc_q;
    assign start_off_o  = start_off_q;
    assign tail_bytes_o = tail_q;

    // ---------------------------------------------------------------------------
    // assertions
    // ---------------------------------------------------------------------------

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else $error("AW payload changed while waiting for AWREADY");

    // AWVALID only two cycles after a start or a completed burst
    a_aw_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(aw_valid_o) |-> $past(start_i || b_fire_i, 2))
        else $error("AWVALID raised without a start or a completed burst");

endmodule

// File: design/wr_data_channel.sv
module wr_data_channel
    import axi_wr_pkg::*;
    import wr_ctrl_pkg::*;
#(
    parameter int DATA_W      = 32,
    parameter int SRAM_ADDR_W = 16,
    localparam int STRB_W     = DATA_W / 8,
    localparam int OFF_W      = $clog2(STRB_W)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  logic                   aw_fire_i,
    input  burst_desc_t            desc_i,
    input  logic [OFF_W-1:0]       start_off_i,
    input  logic [OFF_W-1:0]       tail_bytes_i,
    input  logic                   w_ready_i,
    input  logic [DATA_W-1:0]      sram_data_i,
    output logic [DATA_W-1:0]      w_data_o,
    output logic [STRB_W-1:0]      w_strb_o,
    output logic                   w_last_o,
    output logic                   w_valid_o,
    output logic                   w_done_o,
    output logic                   sram_req_o,
    output logic [SRAM_ADDR_W-1:0] sram_addr_o
);

    typedef logic [STRB_W-1:0]      strb_t;
    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

    logic       w_valid_q;
    logic       w_last_q;
    logic       w_done_q;
    logic       w_fire;
    logic       last_next;
    axi_len_t   beat_cnt_q;
    strb_t      strb_q;
    strb_t      lead_strb;
    strb_t      tail_strb;
    strb_t      strb_first;
    strb_t      strb_next;
    strb_max_t  lead_full;
    strb_max_t  tail_full;
    sram_addr_t sram_addr_q;

    assign w_fire = w_valid_q & w_ready_i;

    // ---------------------------------------------------------------------------
    // strobe masks
    // ---------------------------------------------------------------------------

    always_comb begin
        lead_full = lead_mask(byte_off_t'(start_off_i));
        tail_full = tail_mask(byte_off_t'(tail_bytes_i));
        lead_strb = lead_full[STRB_W-1:0];
        tail_strb = tail_full[STRB_W-1:0];

        // beat 0 of a burst, may be both head and tail
        strb_first = '1;
        if (desc_i.is_first) begin
            strb_first = strb_first & lead_strb;
        end
        if (desc_i.is_final && desc_i.len == '0) begin
            strb_first = strb_first & tail_strb;
        end

        last_next = (axi_len_t'(beat_cnt_q + 8'd1) == desc_i.len);

        // later beats can only be a tail
        strb_next = '1;
        if (desc_i.is_final && last_next) begin
            strb_next = tail_strb;
        end
    end

    // ---------------------------------------------------------------------------
    // beat counter, WVALID and WLAST
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_valid_q  <= 1'b0;
            w_last_q   <= 1'b0;
            w_done_q   <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            if (aw_fire_i) begin
                w_valid_q  <= 1'b1;
                w_last_q   <= (desc_i.len == '0);
                beat_cnt_q <= '0;
            end else if (w_fire) begin
                if (w_last_q) begin
                    w_valid_q <= 1'b0;
                    w_last_q  <= 1'b0;
                end else begin
                    beat_cnt_q <= beat_cnt_q + 8'd1;
                    // registered one beat ahead
                    w_last_q   <= last_next;
                end
            end
            w_done_q <= w_fire & w_last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire_i) begin
            strb_q <= strb_first;
        end else if (w_fire && !w_last_q) begin
            strb_q <= strb_next;
        end
    end

    // ---------------------------------------------------------------------------
    // SRAM fetch
    // ---------------------------------------------------------------------------

    // fetch beat 0 on AW, then one word per accepted beat
    assign sram_req_o = aw_fire_i | (w_fire & ~w_last_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sram_addr_q <= '0;
        end else if (start_i) begin
            sram_addr_q <= '0;
        end else if (sram_req_o) begin
            sram_addr_q <= sram_addr_q + 1'b1;
        end
    end

    assign w_data_o    = sram_data_i;
    assign w_strb_o    = strb_q;
    assign w_last_o    = w_last_q;
    assign w_valid_o   = w_valid_q;
    assign w_done_o    = w_done_q;
    assign sram_addr_o = sram_addr_q;

    // WLAST marks the counted final beat of the burst
    a_wlast_valid: assert property (@(posedge clk) disable iff (!rst_n)
        w_last_o |-> w_valid_o && beat_cnt_q == desc_i.len)
        else $error("WLAST without WVALID or off the final beat");

    // SRAM output must hold while the beat waits
    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=>
            w_valid_o && $stable(w_data_o) && $stable(w_strb_o) && $stable(w_last_o))
        else $error("W payload changed while waiting for WREADY");

endmodule

// File: design/wr_resp_tracker.sv
module wr_resp_tracker
    import axi_wr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  logic      w_done_i,
    input  logic      b_valid_i,
    input  axi_resp_e b_resp_i,
    output logic      b_ready_o,
    output logic      b_fire_o,
    output logic      error_o
);

    logic b_ready_q;
    logic error_q;

    assign b_fire_o = b_ready_q & b_valid_i;

    // ready once all data of the burst is out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_ready_q <= 1'b0;
        end else if (w_done_i) begin
            b_ready_q <= 1'b1;
        end else if (b_fire_o) begin
            b_ready_q <= 1'b0;
        end
    end

    // sticky until the next request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_q <= 1'b0;
        end else if (start_i) begin
            error_q <= 1'b0;
        end else if (b_fire_o && b_resp_i[1]) begin
            error_q <= 1'b1;
        end
    end

    assign b_ready_o = b_ready_q;
    assign error_o   = error_q;

    // one burst outstanding, its data never completes while a response waits
    a_b_after_data: assert property (@(posedge clk) disable iff (!rst_n)
        w_done_i |-> !b_ready_q)
        else $error("burst data completed while a response was still pending");

endmodule

// File: design/axi_wr_master.sv
module axi_wr_master
    import axi_wr_pkg::*;
    import wr_ctrl_pkg::*;
#(
    parameter int ADDR_W      = 32,
    parameter int DATA_W      = 32,
    parameter int BYTES_W     = 16,
    parameter int SRAM_ADDR_W = 16,
    localparam int STRB_W     = DATA_W / 8,
    localparam int OFF_W      = $clog2(STRB_W)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // request side
    input  logic [ADDR_W-1:0]      base_addr_i,
    input  logic [BYTES_W-1:0]     byte_num_i,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   error_o,
    // local SRAM
    input  logic [DATA_W-1:0]      sram_data_i,
    output logic [SRAM_ADDR_W-1:0] sram_addr_o,
    output logic                   sram_req_o,
    // AW
    output aw_chan_t               aw_o,
    output logic                   aw_valid_o,
    input  logic                   aw_ready_i,
    // W
    output logic [DATA_W-1:0]      w_data_o,
    output logic [STRB_W-1:0]      w_strb_o,
    output logic                   w_last_o,
    output logic                   w_valid_o,
    input  logic                   w_ready_i,
    // B
    input  axi_resp_e              b_resp_i,
    input  logic                   b_valid_i,
    output logic                   b_ready_o
);

    logic             start_acc;
    logic             aw_fire;
    logic             w_done;
    logic             b_fire;
    burst_desc_t      desc;
    logic [OFF_W-1:0] start_off;
    logic [OFF_W-1:0] tail_bytes;

    // a start while busy is dropped here
    assign start_acc = start_i & ~busy_o;

    wr_burst_planner #(
        .ADDR_W  (ADDR_W),
        .DATA_W  (DATA_W),
        .BYTES_W (BYTES_W)
    ) u_planner (
        .clk          (clk),
        .rst_n        (rst_n),
        .base_addr_i  (base_addr_i),
        .byte_num_i   (byte_num_i),
        .start_i      (start_acc),
        .b_fire_i     (b_fire),
        .aw_ready_i   (aw_ready_i),
        .aw_o         (aw_o),
        .aw_valid_o   (aw_valid_o),
        .aw_fire_o    (aw_fire),
        .desc_o       (desc),
        .start_off_o  (start_off),
        .tail_bytes_o (tail_bytes),
        .busy_o       (busy_o)
    );

    wr_data_channel #(
        .DATA_W      (DATA_W),
        .SRAM_ADDR_W (SRAM_ADDR_W)
    ) u_data (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_acc),
        .aw_fire_i    (aw_fire),
        .desc_i       (desc),
        .start_off_i  (start_off),
        .tail_bytes_i (tail_bytes),
        .w_ready_i    (w_ready_i),
        .sram_data_i  (sram_data_i),
        .w_data_o     (w_data_o),
        .w_strb_o     (w_strb_o),
        .w_last_o     (w_last_o),
        .w_valid_o    (w_valid_o),
        .w_done_o     (w_done),
        .sram_req_o   (sram_req_o),
        .sram_addr_o  (sram_addr_o)
    );

    wr_resp_tracker u_resp (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_acc),
        .w_done_i  (w_done),
        .b_valid_i (b_valid_i),
        .b_resp_i  (b_resp_i),
        .b_ready_o (b_ready_o),
        .b_fire_o  (b_fire),
        .error_o   (error_o)
    );

endmodule

// File: dv/tb_axi_slave_model.sv
module tb_axi_slave_model
    import axi_wr_pkg::*;
#(
    parameter int DATA_W = 32,
    localparam int STRB_W = DATA_W / 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  aw_chan_t          aw_i,
    input  logic              aw_valid_i,
    output logic              aw_ready_o,
    input  logic [DATA_W-1:0] w_data_i,
    input  logic [STRB_W-1:0] w_strb_i,
    input  logic              w_last_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    output axi_resp_e         b_resp_o,
    output logic              b_valid_o,
    input  logic              b_ready_i,
    input  int                err_burst_i
);

    // byte memory, only written lanes exist
    logic [7:0]  mem [int unsigned];
    int          seed;
    int          burst_cnt;
    int          b_wait;
    logic        b_pend;
    logic [31:0] wr_addr;

    initial begin
        seed = 15550;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            b_resp_o   <= OKAY;
            b_pend     <= 1'b0;
            b_wait     <= 0;
            burst_cnt  <= 0;
            wr_addr    <= '0;
        end else begin
            // ready about three cycles in four
            aw_ready_o <= (($random(seed) & 3) != 0);
            w_ready_o  <= (($random(seed) & 3) != 0);
            if (aw_valid_i && aw_ready_o) begin
                wr_addr <= aw_i.addr;
            end
            if (w_valid_i && w_ready_o) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (w_strb_i[i]) begin
                        mem[wr_addr + i] = w_data_i[i*8 +: 8];
                    end
                end
                wr_addr <= wr_addr + STRB_W;
                if (w_last_i) begin
                    b_pend <= 1'b1;
                    b_wait <= $random(seed) & 3;
                end
            end
            // response after a random delay
            if (b_pend && !b_valid_o) begin
                if (b_wait == 0) begin
                    b_valid_o <= 1'b1;
                    b_resp_o  <= (burst_cnt == err_burst_i) ? SLVERR : OKAY;
                    b_pend    <= 1'b0;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                burst_cnt <= burst_cnt + 1;
            end
        end
    end

endmodule

// File: dv/tb_axi_wr_master.sv
module tb_axi_wr_master
    import axi_wr_pkg::*;
;

    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    // summed beats of all requests below
    localparam int WORST_BEATS = 16 + 537 + 5 + 277;
    localparam int PERIOD = 40;

    logic              clk;
    logic              rst_n;
    logic [31:0]       base_addr_i;
    logic [15:0]       byte_num_i;
    logic              start_i;
    logic              busy_o;
    logic              error_o;
    logic [DATA_W-1:0] sram_data_i;
    logic [15:0]       sram_addr_o;
    logic              sram_req_o;
    aw_chan_t          aw_o;
    logic              aw_valid_o;
    logic              aw_ready_i;
    logic [DATA_W-1:0] w_data_o;
    logic [STRB_W-1:0] w_strb_o;
    logic              w_last_o;
    logic              w_valid_o;
    logic              w_ready_i;
    axi_resp_e         b_resp_i;
    logic              b_valid_i;
    logic              b_ready_o;
    int                err_burst;

    // request tracking for the expected values
    logic              started;
    logic [31:0]       req_base;
    int                req_cnt;
    int                beat_idx;
    int                burst_beat;
    int                bursts_done;
    int                cur_len;
    logic              aw_final;
    int                words_left;
    logic [31:0]       exp_aw_addr;
    logic [7:0]        exp_aw_len;
    logic [STRB_W-1:0] exp_strb;
    int                fail_cnt;
    int                tests_run;
    int                tests_failed;
    int                test_fails;

    axi_wr_master #(
        .ADDR_W      (32),
        .DATA_W      (DATA_W),
        .BYTES_W     (16),
        .SRAM_ADDR_W (16)
    ) UUT (
        .clk (clk), .rst_n (rst_n),
        .base_addr_i (base_addr_i), .byte_num_i (byte_num_i), .start_i (start_i),
        .busy_o (busy_o), .error_o (error_o),
        .sram_data_i (sram_data_i), .sram_addr_o (sram_addr_o), .sram_req_o (sram_req_o),
        .aw_o (aw_o), .aw_valid_o (aw_valid_o), .aw_ready_i (aw_ready_i),
        .w_data_o (w_data_o), .w_strb_o (w_strb_o), .w_last_o (w_last_o),
        .w_valid_o (w_valid_o), .w_ready_i (w_ready_i),
        .b_resp_i (b_resp_i), .b_valid_i (b_valid_i), .b_ready_o (b_ready_o)
    );

    tb_axi_slave_model #(.DATA_W (DATA_W)) slave (
        .clk (clk), .rst_n (rst_n),
        .aw_i (aw_o), .aw_valid_i (aw_valid_o), .aw_ready_o (aw_ready_i),
        .w_data_i (w_data_o), .w_strb_i (w_strb_o), .w_last_i (w_last_o),
        .w_valid_i (w_valid_o), .w_ready_o (w_ready_i),
        .b_resp_o (b_resp_i), .b_valid_o (b_valid_i), .b_ready_i (b_ready_o),
        .err_burst_i (err_burst)
    );

    // hashed word pattern of the local SRAM
    function automatic logic [31:0] sram_word(input int k);
        return (32'(k) * 32'h9E37_79B1) ^ 32'hC0DE_5A5A ^ (32'(k) << 20);
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (sram_req_o) begin
            sram_data_i <= sram_word(int'(sram_addr_o));
        end
    end

    // --------------------------------------------------------------------------
    // expected AW and W values
    // --------------------------------------------------------------------------

    always_comb begin
        words_left  = (int'(req_base % STRB_W) + req_cnt + STRB_W - 1) / STRB_W
                      - bursts_done * 256;
        exp_aw_addr = (req_base & ~32'(STRB_W - 1)) + 32'(bursts_done * 256 * STRB_W);
        exp_aw_len  = (words_left > 256) ? 8'd255 : 8'(words_left - 1);
        for (int i = 0; i < STRB_W; i++) begin
            exp_strb[i] = ((req_base & ~32'(STRB_W - 1)) + 32'(beat_idx * STRB_W + i)
                           >= req_base)
                       && ((req_base & ~32'(STRB_W - 1)) + 32'(beat_idx * STRB_W + i)
                           < req_base + 32'(req_cnt));
        end
    end

    always @(posedge clk) begin
        if (start_i && !busy_o) begin
            req_base    <= base_addr_i;
            req_cnt     <= int'(byte_num_i);
            beat_idx    <= 0;
            bursts_done <= 0;
        end
        if (aw_valid_o && aw_ready_i) begin
            cur_len    <= int'(exp_aw_len);
            burst_beat <= 0;
            aw_final   <= (words_left <= 256);
        end
        if (w_valid_o && w_ready_i) begin
            beat_idx   <= beat_idx + 1;
            burst_beat <= burst_beat + 1;
        end
        if (b_valid_i && b_ready_o) begin
            bursts_done <= bursts_done + 1;
        end
    end

    // --------------------------------------------------------------------------
    // checking assertions
    // --------------------------------------------------------------------------

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !(busy_o | error_o | aw_valid_o | w_valid_o | w_last_o
                       | b_ready_o | sram_req_o))
        else begin $display("an output was high before the first start"); fail_cnt++; end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else begin $display("AW valid or payload dropped before AWREADY"); fail_cnt++; end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o)
                                    && $stable(w_last_o))
        else begin $display("W valid or payload dropped before WREADY"); fail_cnt++; end

    a_aw_addr: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && aw_ready_i |-> aw_o.addr == exp_aw_addr)
        else begin
            $display("FAILED aw_o.addr got %h exp %h", $sampled(aw_o.addr),
                     $sampled(exp_aw_addr));
            fail_cnt++;
        end

    a_aw_len: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && aw_ready_i |-> aw_o.len == exp_aw_len)
        else begin
            $display("FAILED aw_o.len got %h exp %h", $sampled(aw_o.len),
                     $sampled(exp_aw_len));
            fail_cnt++;
        end

    // WLAST on the last beat and nowhere else
    a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && w_ready_i |-> w_last_o == (burst_beat == cur_len))
        else begin
            $display("FAILED w_last_o got %h exp %h", $sampled(w_last_o),
                     $sampled(burst_beat == cur_len));
            fail_cnt++;
        end

    a_w_strb: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && w_ready_i |-> w_strb_o == exp_strb)
        else begin
            $display("FAILED w_strb_o got %h exp %h", $sampled(w_strb_o),
                     $sampled(exp_strb));
            fail_cnt++;
        end

    a_w_data: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && w_ready_i |-> w_data_o == sram_word(beat_idx))
        else begin
            $display("FAILED w_data_o got %h exp %h", $sampled(w_data_o),
                     sram_word($sampled(beat_idx)));
            fail_cnt++;
        end

    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid_i && b_ready_o && aw_final |=> !busy_o)
        else begin $display("busy did not fall after the final response"); fail_cnt++; end

    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_i && busy_o && !(b_valid_i && b_ready_o) |=> busy_o && $stable(error_o))
        else begin $display("a start while busy changed the transfer"); fail_cnt++; end

    a_err_clear: assert property (@(posedge clk) disable iff (!rst_n)
        start_i && !busy_o |=> !error_o)
        else begin $display("error flag not cleared by a new start"); fail_cnt++; end

    // --------------------------------------------------------------------------
    // tasks
    // --------------------------------------------------------------------------

    task automatic run_request(input logic [31:0] base, input int cnt, input bit poke);
        int   limit;
        int   n;
        logic poked;
        limit = ((cnt + STRB_W - 1) / STRB_W + 4) * 20;
        poked = 1'b0;
        slave.mem.delete();
        @(posedge clk);
        base_addr_i <= base;
        byte_num_i  <= 16'(cnt);
        start_i     <= 1'b1;
        started     <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        n = 0;
        while ((n < 2 || busy_o) && n < limit) begin
            @(posedge clk);
            // second request while busy and flagged, must be dropped
            if (poke && !poked && error_o) begin
                base_addr_i <= base + 32'h8000;
                byte_num_i  <= 16'd40;
                start_i     <= 1'b1;
                poked = 1'b1;
            end else begin
                start_i <= 1'b0;
            end
            n++;
        end
        if (busy_o) begin
            $display("request at %h did not finish in %0d cycles", base, limit);
            fail_cnt++;
        end
        if (poke && !poked) begin
            $display("request at %h never raised the error flag while busy", base);
            fail_cnt++;
        end
    endtask

    task automatic check_memory(input logic [31:0] base, input int cnt);
        logic [31:0] aligned;
        logic [31:0] a;
        logic [7:0]  exp_byte;
        aligned = base & ~32'(STRB_W - 1);
        for (int i = -STRB_W; i < cnt + STRB_W; i++) begin
            a = base + 32'(i);
            if (i >= 0 && i < cnt) begin
                exp_byte = 8'(sram_word(int'((a - aligned) / STRB_W))
                              >> (((a - aligned) % STRB_W) * 8));
                assert (slave.mem.exists(a) && slave.mem[a] == exp_byte)
                else begin
                    $display("FAILED slave byte %h got %h exp %h", a,
                             slave.mem.exists(a) ? slave.mem[a] : 8'hxx, exp_byte);
                    fail_cnt++;
                end
            end else begin
                assert (!slave.mem.exists(a))
                else begin
                    $display("byte at %h outside the request was written", a);
                    fail_cnt++;
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (fail_cnt == test_fails) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                     fail_cnt - test_fails);
        end
        test_fails = fail_cnt;
    endtask

    initial begin
        #(PERIOD * (WORST_BEATS * 20 + 200));
        $display("watchdog expired, run stopped");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        start_i     = 1'b0;
        base_addr_i = '0;
        byte_num_i  = '0;
        sram_data_i = '0;
        err_burst   = -1;
        started     = 1'b0;
        req_base    = '0;
        req_cnt     = 0;
        beat_idx    = 0;
        burst_beat  = 0;
        bursts_done = 0;
        cur_len     = 0;
        aw_final    = 1'b0;
        fail_cnt    = 0;
        test_fails  = 0;
        tests_run   = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        repeat (8) @(posedge clk);
        end_test("quiet after reset");

        run_request(32'h0000_1000, 64, 1'b0);
        check_memory(32'h0000_1000, 64);
        end_test("aligned single burst");

        // 537 words, bursts of 256, 256, 25
        run_request(32'h0001_0000, 2148, 1'b0);
        check_memory(32'h0001_0000, 2148);
        end_test("multi burst");

        run_request(32'h0000_2001, 2, 1'b0);
        check_memory(32'h0000_2001, 2);
        run_request(32'h0000_3002, 13, 1'b0);
        check_memory(32'h0000_3002, 13);
        end_test("unaligned strobes");

        // first burst of the next request answers SLVERR
        err_burst = slave.burst_cnt;
        run_request(32'h0002_0000, 1100, 1'b1);
        check_memory(32'h0002_0000, 1100);
        assert (error_o)
        else begin $display("FAILED error_o got %h exp %h", error_o, 1'b1); fail_cnt++; end
        err_burst = -1;
        run_request(32'h0000_4000, 8, 1'b0);
        check_memory(32'h0000_4000, 8);
        assert (!error_o)
        else begin $display("FAILED error_o got %h exp %h", error_o, 1'b0); fail_cnt++; end
        end_test("slave error and busy start");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: axi_wr_master.f
design/axi_wr_pkg.sv
design/wr_ctrl_pkg.sv
design/wr_burst_planner.sv
design/wr_data_channel.sv
design/wr_resp_tracker.sv
design/axi_wr_master.sv
dv/tb_axi_slave_model.sv
dv/tb_axi_wr_master.sv

// File: Makefile
VERILATOR ?= verilator

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal \
		--top-module tb_axi_wr_master -f axi_wr_master.f \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
